/* src/fb_pkg.sv */
/*
 * shared raster constants, colour widths and painter FSM state type
 */

package fb_pkg;

    // 640x480 at 60 Hz raster
    localparam int H_RES = 640;    // active pixels per line
    localparam int V_RES = 480;    // active lines per frame

    localparam int H_FP   = 16;    // horizontal front porch
    localparam int H_SYNC = 96;    // hsync pulse width
    localparam int H_BP   = 48;    // horizontal back porch

    localparam int V_FP   = 10;    // vertical front porch
    localparam int V_SYNC = 2;     // vsync pulse, in lines
    localparam int V_BP   = 33;    // vertical back porch

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    localparam int CORDW = 10;     // screen coordinate width

    // colour formats
    localparam int CIDXW = 4;                // framebuffer colour index
    localparam int CHANW = 4;                // per channel
    localparam int COLRW = 3 * CHANW;        // {r, g, b}, red in msbs

    // palette contents, one hex word per line
    localparam string PALETTE_F = "palette.mem";

    // rectangle fill engine
    typedef enum logic [1:0] {
        IDLE,          // ready for a command
        WAIT_BLANK,    // holding command until vertical blanking
        FILL           // writing pixels
    } fill_state_e;

endpackage

/* src/display_timings.sv */
/*
 * 640x480 raster counters, negative sync, data enable
 * and the strobe at the start of vertical blanking
 */

module display_timings (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    output logic [fb_pkg::CORDW-1:0] sx,           // horizontal position
    output logic [fb_pkg::CORDW-1:0] sy,           // vertical position
    output logic                     hsync,
    output logic                     vsync,
    output logic                     de,           // active area
    output logic                     frame_start   // first blanking pixel
);
    import fb_pkg::*;

    // sync windows
    localparam logic [CORDW-1:0] HS_STA = CORDW'(H_RES + H_FP);
    localparam logic [CORDW-1:0] HS_END = CORDW'(H_RES + H_FP + H_SYNC);
    localparam logic [CORDW-1:0] VS_STA = CORDW'(V_RES + V_FP);
    localparam logic [CORDW-1:0] VS_END = CORDW'(V_RES + V_FP + V_SYNC);

    localparam logic [CORDW-1:0] H_LAST = CORDW'(H_TOTAL - 1);
    localparam logic [CORDW-1:0] V_LAST = CORDW'(V_TOTAL - 1);
    localparam logic [CORDW-1:0] H_ACT  = CORDW'(H_RES);
    localparam logic [CORDW-1:0] V_ACT  = CORDW'(V_RES);

    // raster position
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;                                   // new line
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;      // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // syncs are active low
    assign hsync = ~((sx >= HS_STA) && (sx < HS_END));
    assign vsync = ~((sy >= VS_STA) && (sy < VS_END));

    assign de = (sx < H_ACT) && (sy < V_ACT);

    // one pulse per frame, first cycle of vertical blanking
    assign frame_start = (sx == '0) && (sy == V_ACT);

endmodule

/* src/fb_painter.sv */
/*
 * rectangle fill engine, valid/ready command port,
 * framebuffer writes only in vertical blanking
 */

module fb_painter #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic                                   clk_pix,
    input  logic                                   rst_n,
    input  logic                                   fill_valid,
    input  logic [$clog2(FB_WIDTH)-1:0]            fill_x0,
    input  logic [$clog2(FB_HEIGHT)-1:0]           fill_y0,
    input  logic [$clog2(FB_WIDTH)-1:0]            fill_x1,
    input  logic [$clog2(FB_HEIGHT)-1:0]           fill_y1,
    input  logic [fb_pkg::CIDXW-1:0]               fill_cidx,
    input  logic [fb_pkg::CORDW-1:0]               sy,
    output logic                                   fill_ready,
    output logic                                   we,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0]  waddr,
    output logic [fb_pkg::CIDXW-1:0]               wdata
);
    import fb_pkg::*;

    localparam int XW       = $clog2(FB_WIDTH);
    localparam int YW       = $clog2(FB_HEIGHT);
    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    fill_state_e state, state_next;

    logic [XW-1:0]       x, x0, x1;       // current column and limits
    logic [YW-1:0]       y, y1;           // current row and last row
    logic [CIDXW-1:0]    cidx;            // latched fill colour
    logic [FB_ADDRW-1:0] row_base;        // address of column 0 in row y

    logic accept, blank, last_px;

    assign accept  = fill_valid && fill_ready;
    assign blank   = (sy >= CORDW'(V_RES));        // paint only here
    assign last_px = (x == x1) && (y == y1);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (accept) state_next = WAIT_BLANK;
            WAIT_BLANK: if (blank) state_next = FILL;
            FILL:       if (blank && last_px) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            fill_ready <= 1'b0;
            we         <= 1'b0;
        end else begin
            state      <= state_next;
            fill_ready <= (state_next == IDLE);     // high once idle again
            we         <= (state == FILL) && blank; // stalls during active lines
        end
    end

    // command latch and raster walk over the rectangle
    always_ff @(posedge clk_pix) begin
        if (accept) begin
            x0       <= fill_x0;
            x1       <= fill_x1;
            y1       <= fill_y1;
            cidx     <= fill_cidx;
            x        <= fill_x0;
            y        <= fill_y0;
            row_base <= FB_ADDRW'(fill_y0 * FB_WIDTH);
        end else if ((state == FILL) && blank) begin
            waddr <= row_base + FB_ADDRW'(x);
            wdata <= cidx;
            if (x == x1) begin
                x        <= x0;                     // back to left edge
                y        <= y + 1'b1;
                row_base <= row_base + FB_ADDRW'(FB_WIDTH);
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

/* src/framebuffer.sv */
/*
 * simple dual-port ram of colour indices, registered read
 */

module framebuffer #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic                                  clk_pix,
    input  logic                                  we,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] waddr,
    input  logic [fb_pkg::CIDXW-1:0]              wdata,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] raddr,
    output logic [fb_pkg::CIDXW-1:0]              rdata
);
    import fb_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    logic [CIDXW-1:0] mem [FB_PIXELS];    // one index per pixel

    always_ff @(posedge clk_pix) begin
        if (we) mem[waddr] <= wdata;      // painter port
        rdata <= mem[raddr];              // fetch port, one cycle latency
    end

endmodule

/* src/fb_fetch.sv */
/*
 * framebuffer line reader with palette lookup,
 * feeds the linebuffer one row per request
 */

module fb_fetch #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic                                  clk_pix,
    input  logic                                  rst_n,
    input  logic                                  frame_start,
    input  logic                                  line_req,
    input  logic [fb_pkg::CIDXW-1:0]              rdata,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] raddr,
    output logic                                  pix_en,
    output logic [fb_pkg::COLRW-1:0]              pix_colr
);
    import fb_pkg::*;

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);
    localparam int CNTW      = $clog2(FB_WIDTH + 1);

    logic [COLRW-1:0] palette [2**CIDXW];  // colour lookup rom

    initial $readmemh(PALETTE_F, palette);

    logic [CNTW-1:0]  cnt_h;               // pixels issued in this line
    logic             issuing;
    logic             en_1, en_2;          // ram, index stages
    logic [CIDXW-1:0] cidx_q;              // breaks ram to rom path

    assign issuing = (cnt_h < CNTW'(FB_WIDTH));

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cnt_h  <= CNTW'(FB_WIDTH);     // idle
            raddr  <= '0;
            en_1   <= 1'b0;
            en_2   <= 1'b0;
            pix_en <= 1'b0;
        end else begin
            if (line_req) begin
                cnt_h <= '0;
            end else if (issuing) begin
                cnt_h <= cnt_h + 1'b1;
            end

            if (frame_start) begin
                raddr <= '0;               // row 0 next
            end else if (issuing) begin
                raddr <= (raddr == FB_ADDRW'(FB_PIXELS - 1)) ? '0 : raddr + 1'b1;
            end

            en_1   <= issuing;
            en_2   <= en_1;
            pix_en <= en_2;                // lines up with pix_colr
        end
    end

    // colour data path
    always_ff @(posedge clk_pix) begin
        cidx_q   <= rdata;
        pix_colr <= palette[cidx_q];
    end

endmodule

/* src/linebuffer.sv */
/*
 * double line store, repeats each pixel and each line SCALE times,
 * requests framebuffer rows ahead of display
 */

module linebuffer #(
    parameter int FB_WIDTH = 160,
    parameter int SCALE    = 4
) (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    input  logic [fb_pkg::CORDW-1:0] sx,
    input  logic [fb_pkg::CORDW-1:0] sy,
    input  logic                     de,
    input  logic                     pix_en,
    input  logic [fb_pkg::COLRW-1:0] pix_colr,
    output logic                     line_req,
    output logic [fb_pkg::COLRW-1:0] lb_colr
);
    import fb_pkg::*;

    localparam int XW = $clog2(FB_WIDTH + 1);    // room for one past the end
    localparam int RW = (SCALE > 1) ? $clog2(SCALE) : 1;

    localparam logic [CORDW-1:0] LAST_ACT = CORDW'(V_RES - 1);
    localparam logic [CORDW-1:0] LAST_ROW = CORDW'(V_TOTAL - 1);
    localparam logic [CORDW-1:0] SWAP_X   = CORDW'(H_RES);   // first blanking pixel
    localparam logic [CORDW-1:0] SC       = CORDW'(SCALE);
    localparam logic [CORDW-1:0] SC_LAST  = CORDW'(SCALE - 1);

    logic [COLRW-1:0] store_0 [FB_WIDTH];
    logic [COLRW-1:0] store_1 [FB_WIDTH];

    logic          rd_sel;       // store on display, other one is loading
    logic [XW-1:0] wr_x;         // load position
    logic [XW-1:0] rd_x;         // display position in stored line
    logic [RW-1:0] rep;          // horizontal repeat count
    logic          load_line;    // line that fetches the next row

    // last line of each group except the final one,
    // plus the last raster line to preload row 0
    assign load_line = ((sy < LAST_ACT) && ((sy % SC) == SC_LAST))
                       || (sy == LAST_ROW);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            line_req <= 1'b0;
            rd_sel   <= 1'b0;
            wr_x     <= '0;
        end else begin
            line_req <= (sx == '0) && load_line;
            // load is long done by the end of the active part
            if ((sx == SWAP_X) && load_line) rd_sel <= ~rd_sel;

            if (line_req) begin
                wr_x <= '0;
            end else if (pix_en) begin
                wr_x <= wr_x + 1'b1;
            end
        end
    end

    // writes go to the store not on display
    always_ff @(posedge clk_pix) begin
        if (pix_en && rd_sel)  store_0[wr_x] <= pix_colr;
        if (pix_en && !rd_sel) store_1[wr_x] <= pix_colr;
    end

    // horizontal stretch counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_x <= '0;
            rep  <= '0;
        end else if (!de) begin
            rd_x <= '0;                       // parked until next active line
            rep  <= '0;
        end else if (rep == RW'(SCALE - 1)) begin
            rep  <= '0;
            rd_x <= rd_x + 1'b1;              // next stored pixel
        end else begin
            rep  <= rep + 1'b1;
        end
    end

    // one cycle behind de
    always_ff @(posedge clk_pix) begin
        if (de) lb_colr <= rd_sel ? store_1[rd_x] : store_0[rd_x];
    end

endmodule

/* src/video_out.sv */
/*
 * output stage, sync delayed to match colour, blanking
 */

module video_out (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     de,
    input  logic [fb_pkg::COLRW-1:0] lb_colr,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic [fb_pkg::CHANW-1:0] vga_r,
    output logic [fb_pkg::CHANW-1:0] vga_g,
    output logic [fb_pkg::CHANW-1:0] vga_b
);
    import fb_pkg::*;

    logic hsync_1, vsync_1, de_1;    // match linebuffer latency

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hsync_1   <= 1'b1;       // inactive high
            vsync_1   <= 1'b1;
            de_1      <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            hsync_1   <= hsync;
            vsync_1   <= vsync;
            de_1      <= de;
            vga_hsync <= hsync_1;
            vga_vsync <= vsync_1;
            // black outside the active area
            vga_r     <= de_1 ? lb_colr[2*CHANW +: CHANW] : '0;
            vga_g     <= de_1 ? lb_colr[CHANW +: CHANW] : '0;
            vga_b     <= de_1 ? lb_colr[0 +: CHANW] : '0;
        end
    end

endmodule

/* src/fb_display_top.sv */
/*
 * scaled framebuffer display, fill engine to vga pins
 */

module fb_display_top #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int SCALE     = 4
) (
    input  logic                           clk_pix,
    input  logic                           rst_n,
    input  logic                           fill_valid,
    input  logic [$clog2(FB_WIDTH)-1:0]    fill_x0,
    input  logic [$clog2(FB_HEIGHT)-1:0]   fill_y0,
    input  logic [$clog2(FB_WIDTH)-1:0]    fill_x1,
    input  logic [$clog2(FB_HEIGHT)-1:0]   fill_y1,
    input  logic [fb_pkg::CIDXW-1:0]       fill_cidx,
    output logic                           fill_ready,
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output logic [fb_pkg::CHANW-1:0]       vga_r,
    output logic [fb_pkg::CHANW-1:0]       vga_g,
    output logic [fb_pkg::CHANW-1:0]       vga_b,
    output logic                           frame_start
);
    import fb_pkg::*;

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic [CORDW-1:0]    sx, sy;
    logic                hsync, vsync, de;
    logic                we;                  // painter writes
    logic [FB_ADDRW-1:0] waddr, raddr;
    logic [CIDXW-1:0]    wdata, rdata;
    logic                line_req, pix_en;    // fetch handshake
    logic [COLRW-1:0]    pix_colr, lb_colr;

    display_timings i_display_timings (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .frame_start
    );

    fb_painter #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) i_fb_painter (
        .clk_pix, .rst_n, .fill_valid, .fill_x0, .fill_y0, .fill_x1, .fill_y1,
        .fill_cidx, .sy, .fill_ready, .we, .waddr, .wdata
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) i_framebuffer (
        .clk_pix, .we, .waddr, .wdata, .raddr, .rdata
    );

    // producer, three cycles from address to colour
    fb_fetch #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) i_fb_fetch (
        .clk_pix, .rst_n, .frame_start, .line_req, .rdata, .raddr, .pix_en, .pix_colr
    );

    linebuffer #(
        .FB_WIDTH(FB_WIDTH), .SCALE(SCALE)
    ) i_linebuffer (
        .clk_pix, .rst_n, .sx, .sy, .de, .pix_en, .pix_colr, .line_req, .lb_colr
    );

    video_out i_video_out (
        .clk_pix, .rst_n, .hsync, .vsync, .de, .lb_colr,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

/* sim/tb_fb_display.sv */
/*
 * testbench for the scaled framebuffer display: fill commands,
 * framebuffer model, raster rebuilt from the syncs and checked per pixel
 */

module tb_fb_display;
    timeunit 1ns;
    timeprecision 1ps;

    import fb_pkg::*;

    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int SCALE     = 4;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int XW        = $clog2(FB_WIDTH);
    localparam int YW        = $clog2(FB_HEIGHT);
    localparam int ACT_X     = H_SYNC + H_BP;      // hsync fall to first active pixel
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam bit [31:0] SEED = 32'h992c_d056;

    logic             clk_pix, rst_n;
    logic             fill_valid, fill_ready;
    logic [XW-1:0]    fill_x0, fill_x1;
    logic [YW-1:0]    fill_y0, fill_y1;
    logic [CIDXW-1:0] fill_cidx;
    logic             vga_hsync, vga_vsync, frame_start;
    logic [CHANW-1:0] vga_r, vga_g, vga_b;

    logic [COLRW-1:0] pal   [2**CIDXW];      // expected palette
    logic [CIDXW-1:0] model [FB_PIXELS];     // updated at acceptance
    logic [CIDXW-1:0] shown [FB_PIXELS];     // frame being displayed
    bit model_valid = 1'b0;
    bit shown_valid = 1'b0;
    int frames_checked = 0;
    int accept_wait;                          // cycles the last command waited

    // output raster tracking
    int hcnt = 0, hs_low = 0, vcyc = 0, vs_low = 0, vcnt = 0;
    bit prev_hs = 1'b1, prev_vs = 1'b1;
    bit h_locked = 1'b0, v_locked = 1'b0, v_fall_seen = 1'b0;

    fb_display_top #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .SCALE(SCALE)
    ) i_fb_display_top (
        .clk_pix, .rst_n, .fill_valid, .fill_x0, .fill_y0, .fill_x1, .fill_y1,
        .fill_cidx, .fill_ready, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b,
        .frame_start
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;    // 250 MHz, 4 ns
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("[FAIL] %s: got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_colr(input int px, input int py, input logic [COLRW-1:0] exp);
        assert (vga_r === exp[2*CHANW +: CHANW]) else abort_run($sformatf(
            "[FAIL] vga_r at (%0d,%0d): got %h expected %h", px, py, vga_r, exp[8 +: 4]));
        assert (vga_g === exp[CHANW +: CHANW]) else abort_run($sformatf(
            "[FAIL] vga_g at (%0d,%0d): got %h expected %h", px, py, vga_g, exp[4 +: 4]));
        assert (vga_b === exp[0 +: CHANW]) else abort_run($sformatf(
            "[FAIL] vga_b at (%0d,%0d): got %h expected %h", px, py, vga_b, exp[0 +: 4]));
    endtask

    function automatic int rand_below(input int n);
        return int'($urandom % n);
    endfunction

    task automatic random_rect(output int x0, output int y0, output int x1, output int y1);
        x0 = rand_below(FB_WIDTH);
        y0 = rand_below(FB_HEIGHT);
        x1 = x0 + rand_below(FB_WIDTH - x0);     // inclusive corners, x0 <= x1
        y1 = y0 + rand_below(FB_HEIGHT - y0);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_fill(input int x0, input int y0, input int x1, input int y1,
                             input int c);
        int waited;
        int x, y;
        waited = 0;
        fill_valid = 1'b1;
        fill_x0    = XW'(x0);
        fill_y0    = YW'(y0);
        fill_x1    = XW'(x1);
        fill_y1    = YW'(y1);
        fill_cidx  = CIDXW'(c);
        while (!fill_ready) begin                // command held meanwhile
            @(negedge clk_pix);
            waited++;
            if (waited > FRAME_CYC) abort_run("timeout waiting for fill_ready");
        end
        // transfers on the coming rising edge
        for (y = y0; y <= y1; y++) begin
            for (x = x0; x <= x1; x++) model[y * FB_WIDTH + x] = CIDXW'(c);
        end
        accept_wait = waited;
        @(negedge clk_pix);
        fill_valid = 1'b0;
    endtask

    task automatic wait_frame_start();
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk_pix);
            cnt++;
            if (cnt > FRAME_CYC + H_TOTAL) abort_run("timeout waiting for frame_start");
        end while (!frame_start);
    endtask

    // output monitor, samples mid cycle
    always @(negedge clk_pix) begin
        int px, py;
        logic [COLRW-1:0] exp_colr;
        if (rst_n) begin
            if (prev_hs && !vga_hsync) begin
                if (h_locked) check_hex("vga_hsync period", hcnt + 1, H_TOTAL);
                hcnt     = 0;
                h_locked = 1'b1;
            end else begin
                hcnt++;
            end
            if (!vga_hsync) hs_low++;
            else if (!prev_hs) begin
                check_hex("vga_hsync low cycles", hs_low, H_SYNC);
                hs_low = 0;
            end

            if (prev_vs && !vga_vsync) begin
                if (v_fall_seen) check_hex("vga_vsync period", vcyc + 1, FRAME_CYC);
                vcyc        = 0;
                v_fall_seen = 1'b1;
            end else begin
                vcyc++;
            end
            if (!vga_vsync) vs_low++;
            else if (!prev_vs) begin
                check_hex("vga_vsync low cycles", vs_low, V_SYNC * H_TOTAL);
                vs_low = 0;
            end

            // line count from vsync rise, which lands on a line start
            if (prev_vs === 1'b0 && vga_vsync) begin
                vcnt     = 0;
                v_locked = 1'b1;
            end else if (v_locked && hcnt == ACT_X) begin
                vcnt++;
            end
            if (v_locked && hcnt == ACT_X && vcnt == V_BP) begin
                shown       = model;             // frame content fixed by now
                shown_valid = model_valid;
            end

            if (h_locked && v_locked) begin
                px = hcnt - ACT_X;
                py = vcnt - V_BP;
                // pins still two cycles behind raster (0, V_RES)
                check_hex("frame_start", frame_start, (px == -2) && (py == V_RES - 1));
                if (px >= 0 && px < H_RES && py >= 0 && py < V_RES) begin
                    if (shown_valid) begin
                        exp_colr = pal[shown[(py / SCALE) * FB_WIDTH + px / SCALE]];
                        check_colr(px, py, exp_colr);
                        if (px == H_RES - 1 && py == V_RES - 1) frames_checked++;
                    end
                end else begin
                    check_colr(px, py, '0);      // blanking is black
                end
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
    end

    initial begin
        int x0, y0, x1, y1, c, cnt;
        void'($urandom(SEED));
        $readmemh(PALETTE_F, pal);
        rst_n      = 1'b0;
        fill_valid = 1'b0;
        fill_x0    = '0;
        fill_y0    = '0;
        fill_x1    = '0;
        fill_y1    = '0;
        fill_cidx  = '0;

        repeat (4) @(negedge clk_pix);
        check_hex("vga_r", vga_r, 0);
        check_hex("vga_g", vga_g, 0);
        check_hex("vga_b", vga_b, 0);
        check_hex("vga_hsync", vga_hsync, 1);    // inactive high
        check_hex("vga_vsync", vga_vsync, 1);
        check_hex("frame_start", frame_start, 0);
        check_hex("fill_ready", fill_ready, 0);
        rst_n = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk_pix);
            cnt++;
        end while (!fill_ready && cnt < 2);
        check_hex("fill_ready after reset", fill_ready, 1);

        // whole screen in one colour
        wait_frame_start();
        send_fill(0, 0, FB_WIDTH - 1, FB_HEIGHT - 1, rand_below(16));
        model_valid = 1'b1;

        repeat (3) begin
            wait_frame_start();
            random_rect(x0, y0, x1, y1);
            send_fill(x0, y0, x1, y1, rand_below(16));
        end

        // second command overlaps the first, order shows on screen
        wait_frame_start();
        x0 = rand_below(FB_WIDTH - 80);
        y0 = rand_below(FB_HEIGHT - 40);
        c  = rand_below(16);
        send_fill(x0, y0, x0 + 79, y0 + 39, c);
        check_hex("fill_ready while busy", fill_ready, 0);
        send_fill(x0 + 40, y0 + 20, x0 + 79, y0 + 39, (c + 1) % 16);
        assert (accept_wait >= 80 * 40) else abort_run($sformatf(
            "second fill accepted after %0d cycles, before the first one finished",
            accept_wait));

        // edges and single pixels on a plain background
        wait_frame_start();
        c = rand_below(16);
        send_fill(0, 0, FB_WIDTH - 1, FB_HEIGHT - 1, c);
        send_fill(FB_WIDTH - 1, 0, FB_WIDTH - 1, FB_HEIGHT - 1, (c + 1) % 16);
        send_fill(0, FB_HEIGHT - 1, FB_WIDTH - 1, FB_HEIGHT - 1, (c + 2) % 16);
        send_fill(0, 0, 0, 0, (c + 3) % 16);
        x0 = 1 + rand_below(FB_WIDTH - 2);
        send_fill(x0, 0, x0, 0, (c + 4) % 16);   // one pixel on the top edge
        send_fill(FB_WIDTH - 1, FB_HEIGHT - 1, FB_WIDTH - 1, FB_HEIGHT - 1, (c + 5) % 16);

        wait_frame_start();
        check_hex("frames_checked", frames_checked, 6);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* src/palette.mem */
// one 12-bit colour per index, hex {r, g, b}
000
00A
0A0
0AA
A00
A0A
A50
AAA
555
55F
5F5
5FF
F55
F5F
FF5
FFF

/* files.f */
src/fb_pkg.sv
src/display_timings.sv
src/fb_painter.sv
src/framebuffer.sv
src/fb_fetch.sv
src/linebuffer.sv
src/video_out.sv
src/fb_display_top.sv
sim/tb_fb_display.sv

/* Makefile */
# Verilator build, run and lint for the framebuffer display

VERILATOR  ?= verilator
TOP        ?= tb_fb_display
RTL_TOP    ?= fb_display_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
RUN_DIR    ?= src
VFLAGS     ?= --binary --assert --timing --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# palette.mem is loaded relative to the run directory
run: build
	cd $(RUN_DIR) && $(CURDIR)/$(OBJ_DIR)/V$(TOP) > $(CURDIR)/$(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
